//--- Makefile
# verilator build and run of the ray generator testbench

SRCS := rt_pkg.sv pixel_if.sv frame_scanner.sv raster_counter.sv pipe_delay.sv \
        inv_sqrt.sv ray_generator.sv ray_gen_top.sv ray_gen_chk.sv tb_ray_gen.sv

.PHONY: all run clean

all: obj_dir/Vtb_ray_gen

# rebuilt only when a source or the file list changes
obj_dir/Vtb_ray_gen: $(SRCS) filelist.f
	verilator --binary --assert -j 0 --top-module tb_ray_gen -f filelist.f

# exit status of the simulator is the test result
run: obj_dir/Vtb_ray_gen
	./obj_dir/Vtb_ray_gen

clean:
	rm -rf obj_dir

//--- filelist.f
rt_pkg.sv
pixel_if.sv
frame_scanner.sv
raster_counter.sv
pipe_delay.sv
inv_sqrt.sv
ray_generator.sv
ray_gen_top.sv
ray_gen_chk.sv
tb_ray_gen.sv

//--- frame_scanner.sv
`timescale 1ns/1ps

module frame_scanner (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic at_last,
    input  logic ray_last,
    output logic step,
    output logic clear,
    output logic busy,
    output logic done
);

    typedef enum logic [1:0] {
        IDLE,
        SCAN,
        DRAIN
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   accept;

    // start only counts while idle
    assign accept = (state == IDLE) && start;

    // first strobe must leave on the same edge that takes start,
    // so step and clear are decoded, not registered
    assign clear = accept;
    assign step  = accept || ((state == SCAN) && !at_last);
    assign busy  = (state != IDLE);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_nxt = SCAN;
                end
            end
            SCAN: begin
                // counter holds the final pixel, stop stepping
                if (at_last) begin
                    state_nxt = DRAIN;
                end
            end
            DRAIN: begin
                // wait for the last ray to leave the pipe
                if (ray_last) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= IDLE;
            done  <= 1'b0;
        end else begin
            state <= state_nxt;
            // one pulse, same edge busy drops
            done  <= (state == DRAIN) && ray_last;
        end
    end

endmodule

//--- inv_sqrt.sv
`timescale 1ns/1ps

module inv_sqrt (
    input  logic     clk,
    input  logic     rst,
    input  logic     valid_in,
    input  rt_pkg::fp x,
    output logic     valid_out,
    output rt_pkg::fp inv_sqrt
);

    import rt_pkg::*;

    // stage 0 holds the seed, the rest one newton step each
    logic [INV_SQRT_LAT-1:0] v_s;
    fp                       x_s [INV_SQRT_LAT];
    fp                       y_s [INV_SQRT_LAT];

    int msb;
    int lead_pos;
    int half_pos;
    fp  seed;

    // y' = y * (1.5 - (x/2) * y * y), all products truncated
    function automatic fp newton_step(input fp xv, input fp yv);
        fp half_x;
        fp t;
        half_x = xv >>> 1;
        t      = fp_mul(fp_mul(half_x, yv), yv);
        return fp_mul(FP_THREE_HALVES - t, yv);
    endfunction

    // leading one of x
    // lead_pos counts bits above bit 23, so x in [2^(p-1), 2^p)
    // seed 2^-floor(p/2) keeps y*sqrt(x) inside (0.7, 1.42)
    always_comb begin
        msb = 0;
        for (int i = 0; i < 31; i++) begin
            if (x[i]) begin
                msb = i;
            end
        end
        lead_pos = msb - 23;
        half_pos = lead_pos >>> 1;
        if (half_pos >= 0) begin
            seed = FP_ONE >>> half_pos;
        end else if (half_pos < -6) begin
            // tiny x, clamp to the largest safe power of two
            seed = FP_ONE <<< 6;
        end else begin
            seed = FP_ONE <<< (-half_pos);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            v_s <= '0;
        end else begin
            v_s[0] <= valid_in;
            for (int i = 1; i < INV_SQRT_LAT; i++) begin
                v_s[i] <= v_s[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        x_s[0] <= x;
        y_s[0] <= seed;
        for (int i = 1; i < INV_SQRT_LAT; i++) begin
            x_s[i] <= x_s[i-1];
            y_s[i] <= newton_step(x_s[i-1], y_s[i-1]);
        end
    end

    assign valid_out = v_s[INV_SQRT_LAT-1];
    assign inv_sqrt  = y_s[INV_SQRT_LAT-1];

endmodule

//--- pipe_delay.sv
`timescale 1ns/1ps

module pipe_delay #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    input  T     in_data,
    output logic out_valid,
    output T     out_data
);

    logic [DEPTH-1:0] valid_q;
    T                 data_q [DEPTH];

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= in_valid;
            for (int i = 1; i < DEPTH; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // payload shifts every cycle
    always_ff @(posedge clk) begin
        data_q[0] <= in_data;
        for (int i = 1; i < DEPTH; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    assign out_valid = valid_q[DEPTH-1];
    assign out_data  = data_q[DEPTH-1];

endmodule

//--- pixel_if.sv
`timescale 1ns/1ps

// one pixel coordinate per cycle, no stall
interface pixel_if;

    logic       valid;
    logic [9:0] px;
    logic [8:0] py;
    // strobe of the frame's final pixel
    logic       last;

    // raster counter side
    modport src (
        output valid, px, py, last
    );

    // ray generator side
    modport dst (
        input valid, px, py, last
    );

endinterface

//--- raster_counter.sv
`timescale 1ns/1ps

module raster_counter (
    input  logic   clk,
    input  logic   rst,
    input  logic   clear,
    input  logic   step,
    output logic   at_last,
    pixel_if.src   pix
);

    import rt_pkg::*;

    // position of the next pixel to emit
    logic [9:0] col;
    logic [8:0] row;
    logic [9:0] col_cur;
    logic [8:0] row_cur;
    logic       end_col;
    logic       end_frame;

    // clear may come together with the first step
    always_comb begin
        col_cur   = clear ? '0 : col;
        row_cur   = clear ? '0 : row;
        end_col   = (col_cur == 10'(SCREEN_WIDTH - 1));
        end_frame = end_col && (row_cur == 9'(SCREEN_HEIGHT - 1));
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            col       <= '0;
            row       <= '0;
            at_last   <= 1'b0;
            pix.valid <= 1'b0;
        end else begin
            pix.valid <= step;
            if (step) begin
                at_last <= end_frame;
                if (end_frame) begin
                    col <= '0;
                    row <= '0;
                end else if (end_col) begin
                    col <= '0;
                    row <= row_cur + 9'd1;
                end else begin
                    col <= col_cur + 10'd1;
                    row <= row_cur;
                end
            end
        end
    end

    // coordinates only matter with the strobe
    always_ff @(posedge clk) begin
        if (step) begin
            pix.px   <= col_cur;
            pix.py   <= row_cur;
            pix.last <= end_frame;
        end
    end

endmodule

//--- ray_gen_chk.sv
`timescale 1ns/1ps

module ray_gen_chk (
    input logic       clk,
    input logic       rst,
    input logic       pix_valid,
    input logic       ray_valid,
    input logic       ray_last,
    input logic [9:0] ray_px,
    input logic [8:0] ray_py
);

    import rt_pkg::*;

    // fixed pipe depth, strobe in means ray out RAY_LAT later
    // only once the reset history has left the window
    a_latency: assert property (@(posedge clk)
        (rst && $past(rst, RAY_LAT)) |-> (ray_valid == $past(pix_valid, RAY_LAT)))
        else $error("ray_valid does not follow pix.valid by RAY_LAT cycles");

    // frame end marker only rides on the final pixel's ray
    a_last_valid: assert property (@(posedge clk)
        disable iff (!rst) ray_last |-> (ray_valid
            && (ray_px == 10'(SCREEN_WIDTH - 1))
            && (ray_py == 9'(SCREEN_HEIGHT - 1))))
        else $error("ray_last not on the ray of the final pixel");

    // nothing leaves the pipe while reset is held
    a_reset_quiet: assert property (@(posedge clk)
        (!rst && !$past(rst)) |-> (!ray_valid && !ray_last))
        else $error("ray outputs active during reset");

endmodule

bind ray_generator ray_gen_chk i_chk (
    .clk       (clk),
    .rst       (rst),
    .pix_valid (pix.valid),
    .ray_valid (ray_valid),
    .ray_last  (ray_last),
    .ray_px    (ray_px),
    .ray_py    (ray_py)
);

//--- ray_gen_top.sv
`timescale 1ns/1ps

module ray_gen_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  rt_pkg::vec3 camera_forward,
    output logic        busy,
    output logic        done,
    output logic        ray_valid,
    output rt_pkg::vec3 ray_dir,
    output logic [9:0]  ray_px,
    output logic [8:0]  ray_py
);

    logic step;
    logic clear;
    logic at_last;
    // end of frame as seen at the pipe output
    logic ray_last;

    pixel_if pix ();

    frame_scanner u_scanner (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .at_last  (at_last),
        .ray_last (ray_last),
        .step     (step),
        .clear    (clear),
        .busy     (busy),
        .done     (done)
    );

    raster_counter u_counter (
        .clk     (clk),
        .rst     (rst),
        .clear   (clear),
        .step    (step),
        .at_last (at_last),
        .pix     (pix.src)
    );

    ray_generator u_ray_gen (
        .clk            (clk),
        .rst            (rst),
        .pix            (pix.dst),
        .camera_forward (camera_forward),
        .ray_dir        (ray_dir),
        .ray_px         (ray_px),
        .ray_py         (ray_py),
        .ray_valid      (ray_valid),
        .ray_last       (ray_last)
    );

endmodule

//--- ray_generator.sv
`timescale 1ns/1ps

module ray_generator (
    input  logic        clk,
    input  logic        rst,
    pixel_if.dst        pix,
    input  rt_pkg::vec3 camera_forward,
    output rt_pkg::vec3 ray_dir,
    output logic [9:0]  ray_px,
    output logic [8:0]  ray_py,
    output logic        ray_valid,
    output logic        ray_last
);

    import rt_pkg::*;

    logic v1;
    logic v2;
    logic v3;

    // stage 1
    fp ndc_x;
    fp ndc_y;
    fp px_scaled;
    fp py_scaled;

    // stage 2
    fp   sx;
    fp   sy;
    vec3 world;
    vec3 world_q;

    // stage 3
    vec3 ray3;
    fp   mag_sq;

    // normalize
    logic     sqrt_valid;
    fp        inv_mag;
    logic     dly_valid;
    vec3      dly_ray;
    pix_tag_t tag_in;
    pix_tag_t tag_out;
    logic     tag_valid;

    // integer pixel times fixed reciprocal, exact product
    assign px_scaled = fp'(pix.px) * INV_HALF_WIDTH;
    assign py_scaled = fp'(pix.py) * INV_HALF_HEIGHT;

    // screen y grows downward, ndc y grows upward
    always_ff @(posedge clk) begin
        ndc_x <= px_scaled - FP_ONE;
        ndc_y <= FP_ONE - py_scaled;
    end

    // camera to world, forward comes from the top level
    always_comb begin
        sx      = fp_mul(ndc_x, ASPECT_RATIO);
        sy      = ndc_y;
        world.x = fp_mul(sx, CAMERA_RIGHT.x) + fp_mul(sy, CAMERA_UP.x) + camera_forward.x;
        world.y = fp_mul(sx, CAMERA_RIGHT.y) + fp_mul(sy, CAMERA_UP.y) + camera_forward.y;
        world.z = fp_mul(sx, CAMERA_RIGHT.z) + fp_mul(sy, CAMERA_UP.z) + camera_forward.z;
    end

    always_ff @(posedge clk) begin
        world_q <= world;
    end

    // squared length, ray copied alongside it
    always_ff @(posedge clk) begin
        ray3   <= world_q;
        mag_sq <= vec3_dot(world_q, world_q);
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
            v3 <= 1'b0;
        end else begin
            v1 <= pix.valid;
            v2 <= v1;
            v3 <= v2;
        end
    end

    inv_sqrt u_inv_sqrt (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (v3),
        .x         (mag_sq),
        .valid_out (sqrt_valid),
        .inv_sqrt  (inv_mag)
    );

    // ray waits out the inverse square root
    pipe_delay #(
        .T     (vec3),
        .DEPTH (INV_SQRT_LAT)
    ) u_ray_dly (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (v3),
        .in_data   (ray3),
        .out_valid (dly_valid),
        .out_data  (dly_ray)
    );

    assign tag_in = '{px: pix.px, py: pix.py, last: pix.last};

    // tag spans the whole pipe
    pipe_delay #(
        .T     (pix_tag_t),
        .DEPTH (RAY_LAT)
    ) u_tag_dly (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (pix.valid),
        .in_data   (tag_in),
        .out_valid (tag_valid),
        .out_data  (tag_out)
    );

    // stage 8, scale to unit length
    always_ff @(posedge clk) begin
        if (sqrt_valid && dly_valid) begin
            ray_dir.x <= fp_mul(dly_ray.x, inv_mag);
            ray_dir.y <= fp_mul(dly_ray.y, inv_mag);
            ray_dir.z <= fp_mul(dly_ray.z, inv_mag);
        end
    end

    assign ray_valid = tag_valid;
    assign ray_px    = tag_out.px;
    assign ray_py    = tag_out.py;
    assign ray_last  = tag_valid && tag_out.last;

endmodule

//--- rt_pkg.sv
package rt_pkg;

    // signed 8.24 fixed point
    typedef logic signed [31:0] fp;

    typedef struct packed {
        fp x;
        fp y;
        fp z;
    } vec3;

    // rides along with each ray through the pipeline
    typedef struct packed {
        logic [9:0] px;
        logic [8:0] py;
        logic       last;
    } pix_tag_t;

    localparam int SCREEN_WIDTH  = 640;
    localparam int SCREEN_HEIGHT = 480;

    localparam fp FP_ONE          = 32'sh0100_0000;
    localparam fp FP_THREE_HALVES = 32'sh0180_0000;
    // 1/320, 1/240 and 640/480, rounded to nearest
    localparam fp INV_HALF_WIDTH  = 32'sh0000_CCCD;
    localparam fp INV_HALF_HEIGHT = 32'sh0001_1111;
    localparam fp ASPECT_RATIO    = 32'sh0155_5555;

    // pipeline depths
    localparam int INV_SQRT_LAT = 4;
    localparam int RAY_LAT      = 8;

    // camera basis, no roll
    localparam vec3 CAMERA_RIGHT = '{x: FP_ONE, y: 32'sh0, z: 32'sh0};
    localparam vec3 CAMERA_UP    = '{x: 32'sh0, y: FP_ONE, z: 32'sh0};

    // full 64-bit product, keep bits 55:24 (floor)
    function automatic fp fp_mul(input fp a, input fp b);
        logic signed [63:0] prod;
        prod = 64'(a) * 64'(b);
        return prod[55:24];
    endfunction

    function automatic fp vec3_dot(input vec3 a, input vec3 b);
        return fp_mul(a.x, b.x) + fp_mul(a.y, b.y) + fp_mul(a.z, b.z);
    endfunction

    function automatic fp int_to_fp(input int v);
        return fp'(v <<< 24);
    endfunction

endpackage

//--- tb_ray_gen.sv
`timescale 1ns/1ps

module tb_ray_gen;

    import rt_pkg::*;

    localparam int FRAME_PIXELS = SCREEN_WIDTH * SCREEN_HEIGHT;
    localparam int FRAME_CYCLES = FRAME_PIXELS + RAY_LAT + 20;
    localparam int NUM_FRAMES   = 3;
    // reset, idle windows and start overhead
    localparam int EXTRA_CYCLES = 200;
    localparam int WATCHDOG_NS  = (NUM_FRAMES * FRAME_CYCLES + EXTRA_CYCLES) * 40;

    logic        clk;
    logic        rst;
    logic        start;
    vec3         camera_forward;
    logic        busy;
    logic        done;
    logic        ray_valid;
    vec3         ray_dir;
    logic [9:0]  ray_px;
    logic [8:0]  ray_py;

    // owned by the stimulus process
    vec3         exp_cam;
    int          frame_seq;
    logic [31:0] rng_state;

    // owned by the compare process
    int          seen_seq;
    logic        frame_open;
    int          exp_px;
    int          exp_py;
    int          ray_count;
    int          done_count;
    logic        prev_valid;
    logic        prev_busy;

    ray_gen_top i_dut (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .camera_forward (camera_forward),
        .busy           (busy),
        .done           (done),
        .ray_valid      (ray_valid),
        .ray_dir        (ray_dir),
        .ray_px         (ray_px),
        .ray_py         (ray_py)
    );

    // 40 ns period
    always #20 clk = ~clk;

    task automatic check(input logic [95:0] got, input logic [95:0] exp, input string what);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // each component uniform over [-1, 1]
    task automatic draw_camera(output vec3 cam);
        rng_state = xorshift32(rng_state);
        cam.x     = fp'(rng_state % 32'd33554433) - FP_ONE;
        rng_state = xorshift32(rng_state);
        cam.y     = fp'(rng_state % 32'd33554433) - FP_ONE;
        rng_state = xorshift32(rng_state);
        cam.z     = fp'(rng_state % 32'd33554433) - FP_ONE;
    endtask

    // expected unit ray for one pixel, step by step with truncating products
    function automatic vec3 ref_ray_dir(input int px, input int py, input vec3 cam);
        fp    ndc_x;
        fp    ndc_y;
        fp    sx;
        fp    sy;
        vec3  w;
        fp    mag_sq;
        fp    y;
        fp    t;
        int   msb;
        int   half_pos;
        logic found;
        vec3  r;
        ndc_x  = fp'(px) * INV_HALF_WIDTH - FP_ONE;
        ndc_y  = FP_ONE - fp'(py) * INV_HALF_HEIGHT;
        sx     = fp_mul(ndc_x, ASPECT_RATIO);
        sy     = ndc_y;
        w.x    = fp_mul(sx, CAMERA_RIGHT.x) + fp_mul(sy, CAMERA_UP.x) + cam.x;
        w.y    = fp_mul(sx, CAMERA_RIGHT.y) + fp_mul(sy, CAMERA_UP.y) + cam.y;
        w.z    = fp_mul(sx, CAMERA_RIGHT.z) + fp_mul(sy, CAMERA_UP.z) + cam.z;
        mag_sq = fp_mul(w.x, w.x) + fp_mul(w.y, w.y) + fp_mul(w.z, w.z);
        // highest set bit below the sign
        msb   = 0;
        found = 1'b0;
        for (int i = 30; i >= 0; i--) begin
            if (mag_sq[i] && !found) begin
                msb   = i;
                found = 1'b1;
            end
        end
        // seed 2^-floor(p/2), p counted from bit 23
        half_pos = (msb - 23) >>> 1;
        if (half_pos >= 0) begin
            y = FP_ONE >>> half_pos;
        end else if (half_pos < -6) begin
            y = FP_ONE <<< 6;
        end else begin
            y = FP_ONE <<< (-half_pos);
        end
        // newton steps after the seed stage
        for (int k = 0; k < INV_SQRT_LAT - 1; k++) begin
            t = fp_mul(fp_mul(mag_sq >>> 1, y), y);
            y = fp_mul(FP_THREE_HALVES - t, y);
        end
        r.x = fp_mul(w.x, y);
        r.y = fp_mul(w.y, y);
        r.z = fp_mul(w.z, y);
        return r;
    endfunction

    // sampled mid cycle, away from the driving edge
    always @(negedge clk) begin
        if (!rst) begin
            seen_seq   = 0;
            frame_open = 1'b0;
            exp_px     = 0;
            exp_py     = 0;
            ray_count  = 0;
            done_count = 0;
            prev_valid = 1'b0;
            prev_busy  = 1'b0;
        end else begin
            // new frame requested
            if (frame_seq != seen_seq) begin
                seen_seq   = frame_seq;
                frame_open = 1'b1;
                exp_px     = 0;
                exp_py     = 0;
                ray_count  = 0;
                done_count = 0;
            end
            if (!frame_open) begin
                check(96'(ray_valid), 96'(0), "ray_valid outside a frame");
                check(96'(done), 96'(0), "done outside a frame");
                check(96'(busy), 96'(0), "busy while idle");
            end
            if (frame_open && ray_valid) begin
                check(96'(ray_px), 96'(exp_px), "ray_px");
                check(96'(ray_py), 96'(exp_py), "ray_py");
                check(96'(ray_dir), 96'(ref_ray_dir(exp_px, exp_py, exp_cam)), "ray_dir");
                ray_count++;
                // raster order, px fastest
                exp_px++;
                if (exp_px == SCREEN_WIDTH) begin
                    exp_px = 0;
                    exp_py++;
                end
            end
            if (prev_busy && !busy) begin
                check(96'(done), 96'(1), "busy fell without done");
            end
            if (frame_open && done) begin
                check(96'(prev_valid), 96'(1), "done not right after the last ray");
                check(96'(ray_count), 96'(FRAME_PIXELS), "ray count at done");
                check(96'(busy), 96'(0), "busy still high with done");
                done_count++;
                frame_open = 1'b0;
            end
            prev_valid = ray_valid;
            prev_busy  = busy;
        end
    end

    task automatic run_frame(input vec3 cam, input logic stray_start);
        @(posedge clk);
        #1;
        camera_forward = cam;
        exp_cam        = cam;
        start          = 1'b1;
        frame_seq      = frame_seq + 1;
        @(posedge clk);
        #1;
        start = 1'b0;
        if (stray_start) begin
            // start while busy, must be ignored
            repeat (1000) @(posedge clk);
            #1;
            start = 1'b1;
            @(posedge clk);
            #1;
            start = 1'b0;
        end
        @(posedge clk);
        while (done_count == 0) begin
            @(posedge clk);
        end
        // quiet window, late rays or a second done would show here
        repeat (20) @(posedge clk);
        check(96'(done_count), 96'(1), "done pulses in frame");
        check(96'(ray_count), 96'(FRAME_PIXELS), "rays in frame");
    endtask

    initial begin
        vec3 cam;
        clk            = 1'b0;
        rst            = 1'b0;
        start          = 1'b0;
        camera_forward = '0;
        exp_cam        = '0;
        frame_seq      = 0;
        rng_state      = 32'd50394;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b1;
        // idle after reset, compare process watches outputs
        repeat (10) @(posedge clk);
        // looking down -z
        cam = '{x: 32'sh0, y: 32'sh0, z: -FP_ONE};
        run_frame(cam, 1'b0);
        draw_camera(cam);
        run_frame(cam, 1'b1);
        draw_camera(cam);
        run_frame(cam, 1'b0);
        $display("Test completed successfully");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: run timed out before all frames finished");
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

endmodule
